// ==== include/fastio_stamp.svh ====
/* Build stamp word, overwritten by the build flow before each run */

`ifndef FASTIO_STAMP_SVH
`define FASTIO_STAMP_SVH

`define BUILD_STAMP 32'h0B1D_0001

`endif

// ==== src/fastio_pkg.sv ====
/*
 * Register map and shared types for the board I/O register block.
 * Word addressed, 32 slots; anything not listed here reads as zero.
 */

package fastio_pkg;

	//////////////////////////////
	// Widths and counts
	//////////////////////////////

	localparam int ADDR_W = 5;
	localparam int DATA_W = 32;
	localparam int PWM_W = 9;

	localparam int NUM_CLR = 4;
	localparam int NUM_EXT_INT = 6;
	// btn, sw, then the external sources
	localparam int NUM_INT = NUM_EXT_INT + 2;

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic [ADDR_W-1:0] bus_addr_t;
	typedef logic [DATA_W-1:0] bus_data_t;

	// PWM duty value, also used for the phase
	typedef logic [PWM_W-1:0] pwm_t;

	// Red is the top bit, as on the board connector
	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} rgb_t;

	//////////////////////////////
	// Register map
	//////////////////////////////

	localparam bus_addr_t REG_STAMP = 5'd0;
	localparam bus_addr_t REG_PIC = 5'd1;
	localparam bus_addr_t REG_PWR = 5'd3;
	localparam bus_addr_t REG_BTNSW = 5'd4;
	localparam bus_addr_t REG_LED = 5'd5;
	// Colour channel k sits at REG_CLR_BASE + k
	localparam bus_addr_t REG_CLR_BASE = 5'd8;

	// Red reset level per colour channel, dim to bright from the right
	localparam pwm_t CLR_RESET [NUM_CLR] = '{
		9'h003,
		9'h007,
		9'h00F,
		9'h01F
	};

endpackage

// ==== src/fastio_bus_if.sv ====
/*
 * Registered bus request shared by all register blocks.
 * req is a single-cycle pulse; the other fields are valid only with it.
 */

interface fastio_bus_if;
	import fastio_pkg::*;

	logic req;
	logic we;
	bus_addr_t addr;
	bus_data_t wdata;

	modport master (
		output req,
		output we,
		output addr,
		output wdata
	);

	modport slave (
		input req,
		input we,
		input addr,
		input wdata
	);

endinterface

// ==== src/wb_front.sv ====
/*
 * Wishbone classic slave, one transaction at a time, never stalls.
 * The master must hold cyc, stb, we, addr and data until ack.
 * Ack comes two edges after the request is first sampled.
 */

module wb_front (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input fastio_pkg::bus_addr_t i_wb_addr,
	input fastio_pkg::bus_data_t i_wb_data,
	output logic o_wb_ack,
	fastio_bus_if.master bus
);

	logic busy;
	logic accept;

	// A held stb must not be taken twice, so wait out the ack cycle
	assign accept = i_wb_cyc && i_wb_stb && !busy;

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			busy <= 1'b0;
			bus.req <= 1'b0;
			o_wb_ack <= 1'b0;
		end
		else
		begin
			bus.req <= accept;
			// Read data is loaded with req, so ack follows one cycle later
			o_wb_ack <= bus.req;
			if (accept)
				busy <= 1'b1;
			else if (o_wb_ack)
				busy <= 1'b0;
		end
	end

	// Request payload
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			bus.we <= i_wb_we;
			bus.addr <= i_wb_addr;
			bus.wdata <= i_wb_data;
		end
	end

endmodule

// ==== src/board_ctrl.sv ====
/*
 * Power-on counter, board LEDs, and button and switch capture.
 * Buttons and switches are asynchronous and pass a 2-flop synchroniser.
 * The power counter saturates its top bit and keeps wrapping below it.
 */

module board_ctrl (
	input logic i_clk,
	input logic i_rst_n,
	input logic [3:0] i_sw,
	input logic [3:0] i_btn,
	fastio_bus_if.slave bus,
	output logic [3:0] o_led,
	output fastio_pkg::pwm_t o_phase,
	output fastio_pkg::bus_data_t o_pwr,
	output fastio_pkg::bus_data_t o_btnsw,
	output fastio_pkg::bus_data_t o_ledreg,
	output logic o_sw_int,
	output logic o_btn_int
);
	import fastio_pkg::*;

	bus_data_t pwr_count;
	logic [3:0] sw_meta, swnow, swlast, swcfg;
	logic [3:0] btn_meta, btnnow, btncfg, btnstate;
	logic [3:0] led_reg;
	logic wr_btnsw;
	logic wr_led;

	assign wr_btnsw = bus.req && bus.we && (bus.addr == REG_BTNSW);
	assign wr_led = bus.req && bus.we && (bus.addr == REG_LED);

	//////////////////////////////
	// Power counter
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			pwr_count <= '0;
		else if (pwr_count[DATA_W-1])
			pwr_count[DATA_W-2:0] <= pwr_count[DATA_W-2:0] + 1'b1;
		else
			pwr_count <= pwr_count + 1'b1;
	end

	//////////////////////////////
	// Buttons and switches
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			sw_meta <= '0;
			swnow <= '0;
			swlast <= '0;
			swcfg <= '0;
			btn_meta <= '0;
			btnnow <= '0;
			btncfg <= '0;
			btnstate <= '0;
			o_sw_int <= 1'b0;
			o_btn_int <= 1'b0;
		end
		else
		begin
			sw_meta <= i_sw;
			swnow <= sw_meta;
			swlast <= swnow;
			btn_meta <= i_btn;
			btnnow <= btn_meta;

			// Any change, or a switch selected in the config
			o_sw_int <= |((swnow ^ swlast) | swcfg);
			o_btn_int <= |(btnnow & btncfg);

			if (wr_btnsw)
			begin
				// Masked config update, mask in the low byte
				swcfg <= (bus.wdata[3:0] & bus.wdata[11:8]) | (~bus.wdata[3:0] & swcfg);
				btncfg <= (bus.wdata[7:4] & bus.wdata[15:12]) | (~bus.wdata[7:4] & btncfg);
				// Held buttons survive the clear
				btnstate <= btnnow | (btnstate & ~bus.wdata[7:4]);
			end
			else
				btnstate <= btnstate | btnnow;
		end
	end

	//////////////////////////////
	// LEDs
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			led_reg <= '0;
		else if (wr_led)
			led_reg <= (bus.wdata[7:4] & bus.wdata[3:0]) | (~bus.wdata[7:4] & led_reg);
	end

	assign o_led = led_reg;
	assign o_ledreg = {28'h0, led_reg};
	assign o_pwr = pwr_count;
	// Phase for all colour channels
	assign o_phase = pwr_count[PWM_W-1:0];
	assign o_btnsw = {8'h00, btnnow, 4'h0, btncfg, swcfg, btnstate, swnow};

endmodule

// ==== src/bus_pic.sv ====
/*
 * Bus interrupt controller, level sources, write-one-to-clear pending.
 * A pending bit whose source is still high cannot be cleared.
 */

module bus_pic (
	input logic i_clk,
	input logic i_rst_n,
	input logic [fastio_pkg::NUM_INT-1:0] i_src,
	fastio_bus_if.slave bus,
	output fastio_pkg::bus_data_t o_picreg,
	output logic o_bus_int
);
	import fastio_pkg::*;

	logic [NUM_INT-1:0] pending;
	logic [NUM_INT-1:0] enable;
	logic [NUM_INT-1:0] clr_mask;
	logic gie;
	logic wr_pic;

	assign wr_pic = bus.req && bus.we && (bus.addr == REG_PIC);
	assign clr_mask = wr_pic ? bus.wdata[NUM_INT-1:0] : '0;

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			pending <= '0;
			enable <= '0;
			gie <= 1'b0;
			o_bus_int <= 1'b0;
		end
		else
		begin
			// Sources win over the clear
			pending <= (pending & ~clr_mask) | i_src;
			// Bit 15 guards the enable fields
			if (wr_pic && bus.wdata[15])
			begin
				enable <= bus.wdata[23:16];
				gie <= bus.wdata[31];
			end
			o_bus_int <= gie && |(pending & enable);
		end
	end

	assign o_picreg = {gie, 7'h00, enable, 8'h00, pending};

endmodule

// ==== src/clr_led_pwm.sv ====
/*
 * One tri-colour LED channel with 9-bit PWM per colour.
 * The phase must count through all 512 values to give the set duty.
 */

module clr_led_pwm #(
	parameter int CHAN = 0
) (
	input logic i_clk,
	input logic i_rst_n,
	input fastio_pkg::pwm_t i_phase,
	fastio_bus_if.slave bus,
	output fastio_pkg::rgb_t o_rgb,
	output fastio_pkg::bus_data_t o_clrreg
);
	import fastio_pkg::*;

	pwm_t red, green, blue;
	logic wr_clr;

	assign wr_clr = bus.req && bus.we && (bus.addr == bus_addr_t'(REG_CLR_BASE + CHAN));

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			red <= CLR_RESET[CHAN];
			green <= '0;
			blue <= '0;
		end
		else if (wr_clr)
		begin
			// Ninth bits packed in [26:24]
			red <= {bus.wdata[26], bus.wdata[23:16]};
			green <= {bus.wdata[25], bus.wdata[15:8]};
			blue <= {bus.wdata[24], bus.wdata[7:0]};
		end
	end

	// Output high while the phase is below the duty value
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			o_rgb <= '0;
		else
		begin
			o_rgb.r <= (i_phase < red);
			o_rgb.g <= (i_phase < green);
			o_rgb.b <= (i_phase < blue);
		end
	end

	assign o_clrreg = {5'h00, red[8], green[8], blue[8], red[7:0], green[7:0], blue[7:0]};

endmodule

// ==== src/fastio_rdmux.sv ====
/*
 * Read data selection, loaded on every request and held until the next.
 * Loaded for writes too, the master ignores it then.
 */

`include "fastio_stamp.svh"

module fastio_rdmux (
	input logic i_clk,
	input logic i_rst_n,
	input fastio_pkg::bus_data_t i_pwr,
	input fastio_pkg::bus_data_t i_btnsw,
	input fastio_pkg::bus_data_t i_ledreg,
	input fastio_pkg::bus_data_t i_picreg,
	input fastio_pkg::bus_data_t i_clrreg [fastio_pkg::NUM_CLR],
	fastio_bus_if.slave bus,
	output fastio_pkg::bus_data_t o_wb_data
);
	import fastio_pkg::*;

	bus_data_t sel_word;

	always_comb
	begin
		sel_word = '0;
		case (bus.addr)
			REG_STAMP: sel_word = `BUILD_STAMP;
			REG_PIC: sel_word = i_picreg;
			REG_PWR: sel_word = i_pwr;
			REG_BTNSW: sel_word = i_btnsw;
			REG_LED: sel_word = i_ledreg;
			default:
			begin
				// Colour channels, zero for unmapped words
				for (int k = 0; k < NUM_CLR; k++)
				begin
					if (bus.addr == bus_addr_t'(REG_CLR_BASE + k))
						sel_word = i_clrreg[k];
				end
			end
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			o_wb_data <= '0;
		else if (bus.req)
			o_wb_data <= sel_word;
	end

endmodule

// ==== src/fastio_top.sv ====
/*
 * Board I/O register block on a Wishbone classic slave port.
 * Single cycle transfers only, no stall and no error response.
 * i_sw, i_btn and i_ext_int may be asynchronous only for i_sw and i_btn.
 */

module fastio_top (
	input logic i_clk,
	input logic i_rst_n,
	// Wishbone classic slave
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input fastio_pkg::bus_addr_t i_wb_addr,
	input fastio_pkg::bus_data_t i_wb_data,
	output logic o_wb_ack,
	output fastio_pkg::bus_data_t o_wb_data,
	// Board I/O
	input logic [3:0] i_sw,
	input logic [3:0] i_btn,
	input logic [fastio_pkg::NUM_EXT_INT-1:0] i_ext_int,
	output logic [3:0] o_led,
	output fastio_pkg::rgb_t o_clr_led [fastio_pkg::NUM_CLR],
	output logic o_bus_int
);
	import fastio_pkg::*;

	pwm_t phase;
	bus_data_t pwr_word;
	bus_data_t btnsw_word;
	bus_data_t led_word;
	bus_data_t pic_word;
	bus_data_t clr_word [NUM_CLR];
	logic sw_int;
	logic btn_int;

	fastio_bus_if bus ();

	wb_front u_front (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_addr(i_wb_addr),
		.i_wb_data(i_wb_data),
		.o_wb_ack(o_wb_ack),
		.bus(bus.master)
	);

	board_ctrl u_board (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_sw(i_sw),
		.i_btn(i_btn),
		.bus(bus.slave),
		.o_led(o_led),
		.o_phase(phase),
		.o_pwr(pwr_word),
		.o_btnsw(btnsw_word),
		.o_ledreg(led_word),
		.o_sw_int(sw_int),
		.o_btn_int(btn_int)
	);

	// Source order from bit 0: btn, sw, external
	bus_pic u_pic (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_src({i_ext_int, sw_int, btn_int}),
		.bus(bus.slave),
		.o_picreg(pic_word),
		.o_bus_int(o_bus_int)
	);

	for (genvar k = 0; k < NUM_CLR; k++)
	begin : g_clr
		clr_led_pwm #(
			.CHAN(k)
		) u_clr (
			.i_clk(i_clk),
			.i_rst_n(i_rst_n),
			.i_phase(phase),
			.bus(bus.slave),
			.o_rgb(o_clr_led[k]),
			.o_clrreg(clr_word[k])
		);
	end

	fastio_rdmux u_rdmux (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_pwr(pwr_word),
		.i_btnsw(btnsw_word),
		.i_ledreg(led_word),
		.i_picreg(pic_word),
		.i_clrreg(clr_word),
		.bus(bus.slave),
		.o_wb_data(o_wb_data)
	);

endmodule

// ==== tb/tb_fastio.sv ====
/*
 * Testbench for the board I/O register block, Wishbone classic master.
 * Inputs change on the falling edge, outputs are sampled there too.
 * PWM checks need the power counter to run freely over 512 cycles.
 */

`include "fastio_stamp.svh"

module tb_fastio;
	import fastio_pkg::*;

	localparam int CYCLE_LIMIT = 6000;
	localparam int ACK_WAIT = 8;

	logic i_clk;
	logic i_rst_n;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	bus_addr_t i_wb_addr;
	bus_data_t i_wb_data;
	logic o_wb_ack;
	bus_data_t o_wb_data;
	logic [3:0] i_sw;
	logic [3:0] i_btn;
	logic [NUM_EXT_INT-1:0] i_ext_int;
	logic [3:0] o_led;
	rgb_t o_clr_led [NUM_CLR];
	logic o_bus_int;

	int value_errors = 0;
	int handshake_errors = 0;
	int cycle_count = 0;
	logic [31:0] rng_state = 32'd38785;

	// Reference model state
	logic [3:0] m_led;
	logic [3:0] m_swcfg, m_btncfg, m_btnstate;
	logic [7:0] m_pend, m_en;
	logic m_gie;
	pwm_t m_red, m_green, m_blue;
	bus_data_t wdata, rdata, first_pwr;
	int idx, nr, ng, nb;

	// Red reset level per channel
	localparam pwm_t RED_AT_RESET [NUM_CLR] = '{9'h003, 9'h007, 9'h00F, 9'h01F};

	fastio_top dut_i (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_addr(i_wb_addr),
		.i_wb_data(i_wb_data),
		.o_wb_ack(o_wb_ack),
		.o_wb_data(o_wb_data),
		.i_sw(i_sw),
		.i_btn(i_btn),
		.i_ext_int(i_ext_int),
		.o_led(o_led),
		.o_clr_led(o_clr_led),
		.o_bus_int(o_bus_int)
	);

	always #20 i_clk = ~i_clk;

	//////////////////////////////
	// Handshake rules
	//////////////////////////////

	assert property (@(posedge i_clk) disable iff (!i_rst_n) o_wb_ack |=> !o_wb_ack)
	else
	begin
		handshake_errors++;
		$display("Bus ack stayed high for more than one cycle");
	end

	// Ack two edges after the strobe is first seen
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(i_wb_cyc && i_wb_stb) |-> ##2 o_wb_ack)
	else
	begin
		handshake_errors++;
		$display("Bus ack did not arrive two edges after the strobe");
	end

	always @(posedge i_clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Run stopped after %0d cycles without finishing the tests", cycle_count);
			$display("Errors: value %0d, handshake %0d", value_errors, handshake_errors);
			$display("Regression failed");
			$finish;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Colour word, ninth bits in [26:24]
	function automatic bus_data_t clr_pack(input pwm_t r, input pwm_t g, input pwm_t b);
		return {5'h00, r[8], g[8], b[8], r[7:0], g[7:0], b[7:0]};
	endfunction

	function automatic bus_data_t btnsw_pack(input logic [3:0] bnow, input logic [3:0] sw_now);
		return {8'h00, bnow, 4'h0, m_btncfg, m_swcfg, m_btnstate, sw_now};
	endfunction

	function automatic bus_data_t pic_pack();
		return {m_gie, 7'h00, m_en, 8'h00, m_pend};
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge i_clk);
	endtask

	task automatic run_cycle(input logic we, input bus_addr_t addr, input bus_data_t data,
		output bus_data_t rd);
		int waited;
		waited = 0;
		@(negedge i_clk);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = we;
		i_wb_addr = addr;
		i_wb_data = data;
		@(negedge i_clk);
		while (!o_wb_ack && waited < ACK_WAIT)
		begin
			@(negedge i_clk);
			waited++;
		end
		if (!o_wb_ack)
		begin
			handshake_errors++;
			$display("No ack for the bus cycle at address %0d", addr);
		end
		rd = o_wb_data;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
	endtask

	task automatic write_reg(input bus_addr_t addr, input bus_data_t data);
		bus_data_t unused;
		run_cycle(1'b1, addr, data, unused);
	endtask

	task automatic read_reg(input bus_addr_t addr, output bus_data_t rd);
		run_cycle(1'b0, addr, '0, rd);
	endtask

	task automatic check_word(input string name, input bus_data_t exp, input bus_data_t got);
		assert (got === exp)
		else
		begin
			value_errors++;
			$display("[FAIL] %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic read_check(input string name, input bus_addr_t addr, input bus_data_t exp);
		bus_data_t got;
		read_reg(addr, got);
		check_word(name, exp, got);
	endtask

	task automatic count_high(input int k, output int cr, output int cg, output int cb);
		cr = 0;
		cg = 0;
		cb = 0;
		repeat (512)
		begin
			@(negedge i_clk);
			if (o_clr_led[k].r)
				cr++;
			if (o_clr_led[k].g)
				cg++;
			if (o_clr_led[k].b)
				cb++;
		end
	endtask

	task automatic apply_btnsw_write(input bus_data_t d);
		write_reg(REG_BTNSW, d);
		for (int b = 0; b < 4; b++)
		begin
			// A set mask bit takes the new config bit
			if (d[b])
				m_swcfg[b] = d[8 + b];
			if (d[4 + b])
			begin
				m_btncfg[b] = d[12 + b];
				m_btnstate[b] = 1'b0;
			end
		end
		// Held buttons stay latched
		m_btnstate = m_btnstate | i_btn;
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial
	begin
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		i_sw = '0;
		i_btn = '0;
		i_ext_int = '0;
		m_led = '0;
		m_swcfg = '0;
		m_btncfg = '0;
		m_btnstate = '0;
		m_pend = '0;
		m_en = '0;
		m_gie = 1'b0;
		wait_cycles(2);
		i_rst_n = 1'b1;

		// Reset values and unmapped words
		read_check("o_wb_data REG_STAMP", REG_STAMP, `BUILD_STAMP);
		read_check("o_wb_data REG_LED", REG_LED, 32'h0);
		read_check("o_wb_data REG_PIC", REG_PIC, 32'h0);
		for (int k = 0; k < NUM_CLR; k++)
			read_check("o_wb_data REG_CLR", bus_addr_t'(REG_CLR_BASE + k),
				clr_pack(RED_AT_RESET[k], '0, '0));
		read_check("o_wb_data unmapped 2", 5'd2, 32'h0);
		read_check("o_wb_data unmapped 6", 5'd6, 32'h0);
		read_check("o_wb_data unmapped 7", 5'd7, 32'h0);
		read_check("o_wb_data unmapped 12", 5'd12, 32'h0);
		read_check("o_wb_data unmapped 31", 5'd31, 32'h0);

		// Masked LED writes
		for (int n = 0; n < 20; n++)
		begin
			wdata = next_rand() & 32'hFF;
			write_reg(REG_LED, wdata);
			for (int b = 0; b < 4; b++)
			begin
				if (wdata[4 + b])
					m_led[b] = wdata[b];
			end
			check_word("o_led", {28'h0, m_led}, {28'h0, o_led});
			read_check("o_wb_data REG_LED", REG_LED, {28'h0, m_led});
		end

		// Colour PWM duty per channel
		for (int k = 0; k < NUM_CLR; k++)
		begin
			m_red = pwm_t'(next_rand());
			m_green = pwm_t'(next_rand());
			m_blue = pwm_t'(next_rand());
			write_reg(bus_addr_t'(REG_CLR_BASE + k), clr_pack(m_red, m_green, m_blue));
			read_check("o_wb_data REG_CLR", bus_addr_t'(REG_CLR_BASE + k),
				clr_pack(m_red, m_green, m_blue));
			count_high(k, nr, ng, nb);
			check_word("o_clr_led.r high cycles", 32'(m_red), nr);
			check_word("o_clr_led.g high cycles", 32'(m_green), ng);
			check_word("o_clr_led.b high cycles", 32'(m_blue), nb);
		end

		// Buttons, switches and sticky state
		@(negedge i_clk);
		i_sw = 4'hA;
		i_btn = 4'h5;
		wait_cycles(4);
		m_btnstate = m_btnstate | i_btn;
		read_check("o_wb_data REG_BTNSW", REG_BTNSW, btnsw_pack(4'h5, 4'hA));
		i_btn = 4'h4;
		wait_cycles(4);
		read_check("o_wb_data REG_BTNSW", REG_BTNSW, btnsw_pack(4'h4, 4'hA));
		// Released button goes, held one stays
		apply_btnsw_write(32'h0000_00F0);
		read_check("o_wb_data REG_BTNSW", REG_BTNSW, btnsw_pack(4'h4, 4'hA));
		for (int n = 0; n < 4; n++)
		begin
			apply_btnsw_write(next_rand() & 32'hFFFF);
			read_check("o_wb_data REG_BTNSW", REG_BTNSW, btnsw_pack(4'h4, 4'hA));
		end
		i_btn = 4'h0;
		wait_cycles(4);
		apply_btnsw_write(32'h0000_00FF);
		read_check("o_wb_data REG_BTNSW", REG_BTNSW, btnsw_pack(4'h0, 4'hA));

		// Interrupt controller, all enables on
		write_reg(REG_PIC, 32'h80FF_80FF);
		m_pend = '0;
		m_en = 8'hFF;
		m_gie = 1'b1;
		wait_cycles(2);
		check_word("o_bus_int", 32'h0, {31'h0, o_bus_int});
		read_check("o_wb_data REG_PIC", REG_PIC, pic_pack());
		idx = next_rand() % NUM_EXT_INT;
		@(negedge i_clk);
		i_ext_int = 6'(1) << idx;
		@(negedge i_clk);
		i_ext_int = '0;
		m_pend = m_pend | (8'(1) << (idx + 2));
		wait_cycles(1);
		check_word("o_bus_int", 32'h1, {31'h0, o_bus_int});
		read_check("o_wb_data REG_PIC", REG_PIC, pic_pack());
		// Source held high, the clear must not take
		@(negedge i_clk);
		i_ext_int = 6'(1) << idx;
		write_reg(REG_PIC, 32'(m_pend));
		read_check("o_wb_data REG_PIC", REG_PIC, pic_pack());
		check_word("o_bus_int", 32'h1, {31'h0, o_bus_int});
		@(negedge i_clk);
		i_ext_int = '0;
		write_reg(REG_PIC, 32'(m_pend));
		m_pend = '0;
		wait_cycles(1);
		check_word("o_bus_int", 32'h0, {31'h0, o_bus_int});
		read_check("o_wb_data REG_PIC", REG_PIC, pic_pack());

		// Global enable off
		write_reg(REG_PIC, 32'h00FF_8000);
		m_gie = 1'b0;
		@(negedge i_clk);
		i_ext_int = 6'(1) << idx;
		@(negedge i_clk);
		i_ext_int = '0;
		m_pend = m_pend | (8'(1) << (idx + 2));
		repeat (4)
		begin
			@(negedge i_clk);
			check_word("o_bus_int", 32'h0, {31'h0, o_bus_int});
		end
		read_check("o_wb_data REG_PIC", REG_PIC, pic_pack());

		// Power counter keeps running
		read_reg(REG_PWR, first_pwr);
		read_reg(REG_PWR, rdata);
		assert (rdata > first_pwr)
		else
		begin
			value_errors++;
			$display("[FAIL] o_wb_data REG_PWR first %h second %h", first_pwr, rdata);
		end

		$display("Errors: value %0d, handshake %0d", value_errors, handshake_errors);
		if (value_errors == 0 && handshake_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+include
src/fastio_pkg.sv
src/fastio_bus_if.sv
src/wb_front.sv
src/board_ctrl.sv
src/bus_pic.sv
src/clr_led_pwm.sv
src/fastio_rdmux.sv
src/fastio_top.sv
tb/tb_fastio.sv

// ==== Bender.yml ====
package:
  name: fastio

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/fastio_pkg.sv
      - src/fastio_bus_if.sv
      - src/wb_front.sv
      - src/board_ctrl.sv
      - src/bus_pic.sv
      - src/clr_led_pwm.sv
      - src/fastio_rdmux.sv
      - src/fastio_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_fastio.sv
